//--- Bender.yml
package:
  name: dcache_mem

sources:
  - files:
      - dcache_mem_pkg.sv
      - dcache_sram.sv
      - dcache_rd_arbiter.sv
      - dcache_bank_ctrl.sv
      - dcache_tag_array.sv
      - dcache_data_array.sv
      - dcache_mem.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_dcache_mem.sv

//--- dcache_bank_ctrl.sv
// data bank command generation
// fill, granted read and word write merged into one command per bank
// word write is held off on a bank collision with the read

`timescale 1ns/1ps

module dcache_bank_ctrl (
  input  dcache_mem_pkg::rd_req_t [dcache_mem_pkg::NUM_RD_PORTS-1:0] rd_req_i,
  input  logic                                                       rd_gnt_i,
  input  logic [dcache_mem_pkg::RD_SEL_WIDTH-1:0]                    rd_sel_i,
  input  dcache_mem_pkg::cl_wr_t                                     cl_wr_i,
  input  dcache_mem_pkg::word_wr_t                                   word_wr_i,
  output logic                                                       wr_ack_o,
  output dcache_mem_pkg::bank_cmd_t [dcache_mem_pkg::NUM_BANKS-1:0]  bank_cmd_o
);

  import dcache_mem_pkg::*;

  logic [BANK_SEL_WIDTH-1:0]       rd_bank;
  logic [BANK_SEL_WIDTH-1:0]       wr_bank;
  logic                            wr_req;
  logic                            collision;
  logic [SET_ASSOC*XLEN_BYTES-1:0] fill_be;
  logic [SET_ASSOC*XLEN_BYTES-1:0] word_be;

  assign rd_bank   = rd_req_i[rd_sel_i].off[OFFSET_WIDTH-1:ALIGN_BITS];
  assign wr_bank   = word_wr_i.off[OFFSET_WIDTH-1:ALIGN_BITS];
  assign wr_req    = |word_wr_i.way;
  assign collision = rd_gnt_i && (rd_bank == wr_bank);

  // byte enable lanes, way j owns bytes j*4 .. j*4+3 of each bank
  for (genvar j = 0; j < SET_ASSOC; j++) begin : gen_way_be
    assign fill_be[j*XLEN_BYTES +: XLEN_BYTES] = {XLEN_BYTES{cl_wr_i.we[j]}};
    assign word_be[j*XLEN_BYTES +: XLEN_BYTES] = word_wr_i.way[j] ? word_wr_i.be : '0;
  end

  always_comb begin
    wr_ack_o = 1'b0;
    for (int k = 0; k < NUM_BANKS; k++) begin
      bank_cmd_o[k].req   = 1'b0;
      bank_cmd_o[k].we    = 1'b0;
      bank_cmd_o[k].idx   = word_wr_i.idx;
      bank_cmd_o[k].be    = '0;
      bank_cmd_o[k].wdata = {SET_ASSOC{word_wr_i.data}};
    end

    if (cl_wr_i.vld) begin
      // fill owns every bank, each bank takes its word of the line
      for (int k = 0; k < NUM_BANKS; k++) begin
        bank_cmd_o[k].req   = 1'b1;
        bank_cmd_o[k].we    = 1'b1;
        bank_cmd_o[k].idx   = cl_wr_i.idx;
        bank_cmd_o[k].be    = fill_be;
        bank_cmd_o[k].wdata = {SET_ASSOC{cl_wr_i.data[k*XLEN +: XLEN]}};
      end
    end else begin
      if (rd_gnt_i) begin
        bank_cmd_o[rd_bank].req = 1'b1;
        bank_cmd_o[rd_bank].idx = rd_req_i[rd_sel_i].idx;
      end
      // word write runs alongside the read unless both hit one bank
      if (wr_req && !collision) begin
        wr_ack_o                = 1'b1;
        bank_cmd_o[wr_bank].req = 1'b1;
        bank_cmd_o[wr_bank].we  = 1'b1;
        bank_cmd_o[wr_bank].idx = word_wr_i.idx;
        bank_cmd_o[wr_bank].be  = word_be;
      end
    end
  end

endmodule

//--- dcache_data_array.sv
// data bank RAMs, one bank per word offset
// registered word offset and hit-way word select

`timescale 1ns/1ps

module dcache_data_array (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  dcache_mem_pkg::bank_cmd_t [dcache_mem_pkg::NUM_BANKS-1:0] bank_cmd_i,
  input  logic [dcache_mem_pkg::BANK_SEL_WIDTH-1:0]                 rd_off_i,
  input  logic [dcache_mem_pkg::SET_ASSOC-1:0]                      rd_hit_oh_i,
  output logic [dcache_mem_pkg::XLEN-1:0]                           rd_data_o
);

  import dcache_mem_pkg::*;

  logic [NUM_BANKS-1:0][SET_ASSOC*XLEN-1:0] bank_rdata;
  logic [SET_ASSOC*XLEN-1:0]                rdata_cl;
  logic [BANK_SEL_WIDTH-1:0]                off_q;

  ////////////////////
  // banks
  ////////////////////

  // bank k holds word k of the line for all ways side by side
  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_bank
    dcache_sram #(
      .DataWidth (SET_ASSOC * XLEN),
      .NumWords  (NUM_SETS)
    ) u_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_cmd_i[k].req),
      .we_i    (bank_cmd_i[k].we),
      .addr_i  (bank_cmd_i[k].idx),
      .be_i    (bank_cmd_i[k].be),
      .wdata_i (bank_cmd_i[k].wdata),
      .rdata_o (bank_rdata[k])
    );
  end

  ////////////////////
  // readout
  ////////////////////

  // offset lines up with the bank output a cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      off_q <= '0;
    end else begin
      off_q <= rd_off_i;
    end
  end

  assign rdata_cl = bank_rdata[off_q];

  // and-or mux over the ways, meaningful for a one-hot hit only
  always_comb begin
    rd_data_o = '0;
    for (int j = 0; j < SET_ASSOC; j++) begin
      if (rd_hit_oh_i[j]) begin
        rd_data_o = rd_data_o | rdata_cl[j*XLEN +: XLEN];
      end
    end
  end

endmodule

//--- dcache_mem.f
dcache_mem_pkg.sv
dcache_sram.sv
dcache_rd_arbiter.sv
dcache_bank_ctrl.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_mem.sv
tb_clk_gen.sv
tb_dcache_mem.sv

//--- dcache_mem.sv
// dcache memory core top level
// read arbiter, bank control, tag array and data array

`timescale 1ns/1ps

module dcache_mem (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  // read ports
  input  logic [dcache_mem_pkg::NUM_RD_PORTS-1:0]                    rd_req_i,
  input  logic [dcache_mem_pkg::NUM_RD_PORTS-1:0]                    rd_prio_i,
  input  dcache_mem_pkg::rd_req_t [dcache_mem_pkg::NUM_RD_PORTS-1:0] rd_addr_i,
  input  logic [dcache_mem_pkg::NUM_RD_PORTS-1:0]
               [dcache_mem_pkg::TAG_WIDTH-1:0]                       rd_tag_i,
  output logic [dcache_mem_pkg::NUM_RD_PORTS-1:0]                    rd_ack_o,
  output logic [dcache_mem_pkg::SET_ASSOC-1:0]                       rd_hit_oh_o,
  output logic [dcache_mem_pkg::SET_ASSOC-1:0]                       rd_vld_bits_o,
  output logic [dcache_mem_pkg::XLEN-1:0]                            rd_data_o,
  // line fill
  input  dcache_mem_pkg::cl_wr_t                                     cl_wr_i,
  // single word write
  input  dcache_mem_pkg::word_wr_t                                   word_wr_i,
  output logic                                                       wr_ack_o
);

  import dcache_mem_pkg::*;

  logic                                rd_gnt;
  logic [RD_SEL_WIDTH-1:0]             rd_sel;
  logic [BANK_SEL_WIDTH-1:0]           rd_word_off;
  bank_cmd_t [NUM_BANKS-1:0]           bank_cmd;

  // word offset of whichever port holds the grant
  assign rd_word_off = rd_addr_i[rd_sel].off[OFFSET_WIDTH-1:ALIGN_BITS];

  dcache_rd_arbiter u_rd_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_req_i  (rd_req_i),
    .rd_prio_i (rd_prio_i),
    .hold_i    (cl_wr_i.vld),
    .rd_ack_o  (rd_ack_o),
    .rd_gnt_o  (rd_gnt),
    .rd_sel_o  (rd_sel)
  );

  dcache_bank_ctrl u_bank_ctrl (
    .rd_req_i   (rd_addr_i),
    .rd_gnt_i   (rd_gnt),
    .rd_sel_i   (rd_sel),
    .cl_wr_i    (cl_wr_i),
    .word_wr_i  (word_wr_i),
    .wr_ack_o   (wr_ack_o),
    .bank_cmd_o (bank_cmd)
  );

  dcache_tag_array u_tag_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_addr_i),
    .rd_gnt_i      (rd_gnt),
    .rd_sel_i      (rd_sel),
    .rd_tag_i      (rd_tag_i),
    .cl_wr_i       (cl_wr_i),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_vld_bits_o (rd_vld_bits_o)
  );

  dcache_data_array u_data_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bank_cmd_i  (bank_cmd),
    .rd_off_i    (rd_word_off),
    .rd_hit_oh_i (rd_hit_oh_o),
    .rd_data_o   (rd_data_o)
  );

endmodule

//--- dcache_mem_pkg.sv
// dcache memory core package
// geometry of the cache, request structs and the per-bank command

package dcache_mem_pkg;

  ////////////////////
  // geometry
  ////////////////////

  localparam int unsigned XLEN           = 32;
  localparam int unsigned XLEN_BYTES     = XLEN / 8;
  localparam int unsigned ALIGN_BITS     = $clog2(XLEN_BYTES);
  localparam int unsigned SET_ASSOC      = 4;
  // one data bank per word of the line
  localparam int unsigned NUM_BANKS      = 4;
  localparam int unsigned LINE_WIDTH     = NUM_BANKS * XLEN;
  localparam int unsigned OFFSET_WIDTH   = $clog2(LINE_WIDTH / 8);
  localparam int unsigned BANK_SEL_WIDTH = OFFSET_WIDTH - ALIGN_BITS;
  localparam int unsigned NUM_SETS       = 64;
  localparam int unsigned IDX_WIDTH      = $clog2(NUM_SETS);
  localparam int unsigned TAG_WIDTH      = 8;
  localparam int unsigned NUM_RD_PORTS   = 2;
  // index of a read port, at least one bit wide
  localparam int unsigned RD_SEL_WIDTH   = (NUM_RD_PORTS > 1) ? $clog2(NUM_RD_PORTS) : 1;

  ////////////////////
  // request types
  ////////////////////

  // address of one read port, the tag follows a cycle later
  typedef struct packed {
    logic [IDX_WIDTH-1:0]    idx;
    logic [OFFSET_WIDTH-1:0] off;
  } rd_req_t;

  // cache line fill
  typedef struct packed {
    logic                  vld;
    logic [SET_ASSOC-1:0]  we;
    logic [TAG_WIDTH-1:0]  tag;
    logic [IDX_WIDTH-1:0]  idx;
    logic [SET_ASSOC-1:0]  vld_bits;
    logic [LINE_WIDTH-1:0] data;
  } cl_wr_t;

  // single word write, way is one-hot and doubles as the request
  typedef struct packed {
    logic [SET_ASSOC-1:0]    way;
    logic [IDX_WIDTH-1:0]    idx;
    logic [OFFSET_WIDTH-1:0] off;
    logic [XLEN-1:0]         data;
    logic [XLEN_BYTES-1:0]   be;
  } word_wr_t;

  // command to one data bank, one word lane per way
  typedef struct packed {
    logic                              req;
    logic                              we;
    logic [IDX_WIDTH-1:0]              idx;
    logic [SET_ASSOC*XLEN_BYTES-1:0]   be;
    logic [SET_ASSOC*XLEN-1:0]         wdata;
  } bank_cmd_t;

endpackage

//--- dcache_rd_arbiter.sv
// read port arbiter
// high priority masking, round-robin among equal requests
// nothing is granted while a fill is in progress

`timescale 1ns/1ps

module dcache_rd_arbiter (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [dcache_mem_pkg::NUM_RD_PORTS-1:0]  rd_req_i,
  input  logic [dcache_mem_pkg::NUM_RD_PORTS-1:0]  rd_prio_i,
  input  logic                                     hold_i,
  output logic [dcache_mem_pkg::NUM_RD_PORTS-1:0]  rd_ack_o,
  output logic                                     rd_gnt_o,
  output logic [dcache_mem_pkg::RD_SEL_WIDTH-1:0]  rd_sel_o
);

  import dcache_mem_pkg::*;

  logic [NUM_RD_PORTS-1:0] req_prio;
  logic [NUM_RD_PORTS-1:0] req_masked;
  logic [RD_SEL_WIDTH-1:0] rr_q;

  // low prio requests drop out as soon as one high prio request shows up
  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  ////////////////////
  // round robin
  ////////////////////

  always_comb begin
    int unsigned cand;
    logic        found;
    found    = 1'b0;
    rd_sel_o = rr_q;
    // first requester at or after the pointer
    for (int i = 0; i < NUM_RD_PORTS; i++) begin
      cand = (int'(rr_q) + i) % NUM_RD_PORTS;
      if (!found && req_masked[cand]) begin
        found    = 1'b1;
        rd_sel_o = RD_SEL_WIDTH'(cand);
      end
    end
    rd_gnt_o = found & ~hold_i;
    rd_ack_o = '0;
    if (rd_gnt_o) begin
      rd_ack_o[rd_sel_o] = 1'b1;
    end
  end

  // pointer moves past the port that was just served
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (rd_gnt_o) begin
      rr_q <= RD_SEL_WIDTH'((int'(rd_sel_o) + 1) % NUM_RD_PORTS);
    end
  end

endmodule

//--- dcache_sram.sv
// generic single-port synchronous RAM
// byte write enables, registered read data

`timescale 1ns/1ps

module dcache_sram #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned NumWords  = 64
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NumWords)-1:0]  addr_i,
  input  logic [(DataWidth+7)/8-1:0]   be_i,
  input  logic [DataWidth-1:0]         wdata_i,
  output logic [DataWidth-1:0]         rdata_o
);

  logic [DataWidth-1:0] mem_q [NumWords];

  // storage, byte lanes written under their enable
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int i = 0; i < DataWidth; i++) begin
        if (be_i[i/8]) begin
          mem_q[addr_i][i] <= wdata_i[i];
        end
      end
    end
  end

  // read port, data shows up one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

//--- dcache_tag_array.sv
// tag and valid RAMs, one per way
// delayed compare enable and port select, one-hot hit vector

`timescale 1ns/1ps

module dcache_tag_array (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  input  dcache_mem_pkg::rd_req_t [dcache_mem_pkg::NUM_RD_PORTS-1:0] rd_req_i,
  input  logic                                                       rd_gnt_i,
  input  logic [dcache_mem_pkg::RD_SEL_WIDTH-1:0]                    rd_sel_i,
  input  logic [dcache_mem_pkg::NUM_RD_PORTS-1:0]
               [dcache_mem_pkg::TAG_WIDTH-1:0]                       rd_tag_i,
  input  dcache_mem_pkg::cl_wr_t                                     cl_wr_i,
  output logic [dcache_mem_pkg::SET_ASSOC-1:0]                       rd_hit_oh_o,
  output logic [dcache_mem_pkg::SET_ASSOC-1:0]                       rd_vld_bits_o
);

  import dcache_mem_pkg::*;

  logic [IDX_WIDTH-1:0]                tag_addr;
  logic [SET_ASSOC-1:0]                tag_req;
  logic [SET_ASSOC-1:0][TAG_WIDTH:0]   tag_rdata;
  logic [RD_SEL_WIDTH-1:0]             sel_q;
  logic                                cmp_en_q;

  // fill takes precedence over the lookup address
  assign tag_addr = cl_wr_i.vld ? cl_wr_i.idx : rd_req_i[rd_sel_i].idx;
  assign tag_req  = cl_wr_i.vld ? cl_wr_i.we : {SET_ASSOC{rd_gnt_i}};

  // compare only in the cycle after a read lookup
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q    <= '0;
      cmp_en_q <= 1'b0;
    end else begin
      sel_q    <= rd_sel_i;
      cmp_en_q <= rd_gnt_i & ~cl_wr_i.vld;
    end
  end

  for (genvar i = 0; i < SET_ASSOC; i++) begin : gen_way
    // valid bit on top of the tag
    dcache_sram #(
      .DataWidth (TAG_WIDTH + 1),
      .NumWords  (NUM_SETS)
    ) u_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req[i]),
      .we_i    (cl_wr_i.vld),
      .addr_i  (tag_addr),
      .be_i    ('1),
      .wdata_i ({cl_wr_i.vld_bits[i], cl_wr_i.tag}),
      .rdata_o (tag_rdata[i])
    );

    assign rd_vld_bits_o[i] = tag_rdata[i][TAG_WIDTH];
    // tag of the granted port arrives one cycle late
    assign rd_hit_oh_o[i]   = cmp_en_q & rd_vld_bits_o[i] &
                              (tag_rdata[i][TAG_WIDTH-1:0] == rd_tag_i[sel_q]);
  end

endmodule

//--- tb_clk_gen.sv
// testbench clock and power-on reset

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tb_dcache_mem.sv
// testbench for the dcache memory core
// LFSR stimulus, reference model, checking monitor, watchdog and report

`timescale 1ns/1ps

module tb_dcache_mem;

  import dcache_mem_pkg::*;

  localparam int ClkPeriod      = 40;
  localparam int HandshakeLimit = 16;
  // reset, init, fill_hit, miss, arbitration, word_write, bank_collision
  localparam int RunCycles      = 16 + 2 * NUM_SETS + 60 + 10 + 20 + 20 + 15;

  logic                                   clk_i;
  logic                                   rst_ni;
  logic [NUM_RD_PORTS-1:0]                rd_req;
  logic [NUM_RD_PORTS-1:0]                rd_prio;
  rd_req_t [NUM_RD_PORTS-1:0]             rd_addr;
  logic [NUM_RD_PORTS-1:0][TAG_WIDTH-1:0] rd_tag;
  logic [NUM_RD_PORTS-1:0]                rd_ack;
  logic [SET_ASSOC-1:0]                   rd_hit_oh;
  logic [SET_ASSOC-1:0]                   rd_vld_bits;
  logic [XLEN-1:0]                        rd_data;
  cl_wr_t                                 cl_wr;
  word_wr_t                               word_wr;
  logic                                   wr_ack;

  // reference model of tags, valid bits and lines
  logic [TAG_WIDTH-1:0]  m_tag  [NUM_SETS][SET_ASSOC];
  logic                  m_vld  [NUM_SETS][SET_ASSOC];
  logic [LINE_WIDTH-1:0] m_line [NUM_SETS][SET_ASSOC];
  // lines filled in fill_hit and reused by later tests
  logic [IDX_WIDTH-1:0]  r_idx [6];
  logic [1:0]            r_way [6];
  logic [TAG_WIDTH-1:0]  r_tag [6];
  // read granted last cycle and the model state it must see
  logic                                pend = 1'b0;
  int                                  pend_port;
  logic [SET_ASSOC-1:0]                snap_vld;
  logic [SET_ASSOC-1:0][TAG_WIDTH-1:0] snap_tag;
  logic [SET_ASSOC-1:0][XLEN-1:0]      snap_word;

  logic [15:0] lfsr = 16'd44417;
  string       test_name;
  int          error_cnt;
  int          err_start;
  int          test_cnt;
  int          bad_tests;

  tb_clk_gen #(
    .PeriodNs    (ClkPeriod),
    .ResetCycles (16)
  ) u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  dcache_mem u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req),
    .rd_prio_i     (rd_prio),
    .rd_addr_i     (rd_addr),
    .rd_tag_i      (rd_tag),
    .rd_ack_o      (rd_ack),
    .rd_hit_oh_o   (rd_hit_oh),
    .rd_vld_bits_o (rd_vld_bits),
    .rd_data_o     (rd_data),
    .cl_wr_i       (cl_wr),
    .word_wr_i     (word_wr),
    .wr_ack_o      (wr_ack)
  );

  ////////////////////
  // helpers
  ////////////////////

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [LINE_WIDTH-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  task automatic report_value(input string what, input logic [LINE_WIDTH-1:0] exp,
                              input logic [LINE_WIDTH-1:0] act);
    $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, exp, act);
    error_cnt++;
  endtask

  task automatic report_fail(input string msg);
    $display("[%s] %s", test_name, msg);
    error_cnt++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = error_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    if (error_cnt != err_start) bad_tests++;
    $display("%-15s %0d errors", test_name, error_cnt - err_start);
  endtask

  task automatic fill_line(input logic [IDX_WIDTH-1:0] set_idx, input logic [SET_ASSOC-1:0] we,
                           input logic [TAG_WIDTH-1:0] tag, input logic [SET_ASSOC-1:0] vb,
                           input logic [LINE_WIDTH-1:0] line);
    @(negedge clk_i);
    cl_wr = '{vld: 1'b1, we: we, tag: tag, idx: set_idx, vld_bits: vb, data: line};
    @(negedge clk_i);
    cl_wr.vld = 1'b0;
  endtask

  task automatic read_word(input int port, input logic [IDX_WIDTH-1:0] set_idx,
                           input logic [1:0] woff, input logic [TAG_WIDTH-1:0] tag);
    int waited;
    waited = 0;
    @(negedge clk_i);
    rd_addr[port] = '{idx: set_idx, off: {woff, 2'b00}};
    rd_tag[port]  = tag;
    rd_req[port]  = 1'b1;
    @(posedge clk_i);
    while (!rd_ack[port] && waited < HandshakeLimit) begin
      waited++;
      @(posedge clk_i);
    end
    assert (rd_ack[port]) else report_fail($sformatf("read on port %0d was never acked", port));
    @(negedge clk_i);
    rd_req[port] = 1'b0;
  endtask

  task automatic write_word(input logic [SET_ASSOC-1:0] way_oh,
                            input logic [IDX_WIDTH-1:0] set_idx,
                            input logic [1:0] woff, input logic [XLEN-1:0] data,
                            input logic [XLEN_BYTES-1:0] be);
    int waited;
    waited = 0;
    @(negedge clk_i);
    word_wr = '{way: way_oh, idx: set_idx, off: {woff, 2'b00}, data: data, be: be};
    @(posedge clk_i);
    while (!wr_ack && waited < HandshakeLimit) begin
      waited++;
      @(posedge clk_i);
    end
    assert (wr_ack) else report_fail("word write was never acked");
    @(negedge clk_i);
    word_wr.way = '0;
  endtask

  ////////////////////
  // checking monitor
  ////////////////////

  always @(posedge clk_i) begin : check_results
    logic [SET_ASSOC-1:0] exp_hit;
    logic [XLEN-1:0]      exp_word;
    logic [1:0]           woff;
    if (rst_ni) begin
      if (pend) begin
        exp_hit  = '0;
        exp_word = '0;
        for (int w = 0; w < SET_ASSOC; w++) begin
          exp_hit[w] = snap_vld[w] && (snap_tag[w] == rd_tag[pend_port]);
          if (exp_hit[w]) exp_word = snap_word[w];
        end
        assert ($onehot0(rd_hit_oh)) else report_value("one-hot hit", exp_hit, rd_hit_oh);
        assert (rd_hit_oh == exp_hit) else report_value("hit vector", exp_hit, rd_hit_oh);
        assert (rd_vld_bits == snap_vld) else report_value("valid bits", snap_vld, rd_vld_bits);
        if ($onehot(exp_hit)) begin
          assert (rd_data == exp_word) else report_value("read word", exp_word, rd_data);
        end
      end else begin
        assert (rd_hit_oh == '0) else report_value("hit without a read", '0, rd_hit_oh);
      end
      assert (!(cl_wr.vld && (|rd_ack || wr_ack)))
        else report_fail("an ack was given during a fill");
      // take the snapshot before this cycle's writes land in the model
      pend = |rd_ack;
      if (pend) begin
        pend_port = rd_ack[1] ? 1 : 0;
        woff      = rd_addr[pend_port].off[OFFSET_WIDTH-1:ALIGN_BITS];
        for (int w = 0; w < SET_ASSOC; w++) begin
          snap_vld[w]  = m_vld[rd_addr[pend_port].idx][w];
          snap_tag[w]  = m_tag[rd_addr[pend_port].idx][w];
          snap_word[w] = m_line[rd_addr[pend_port].idx][w][woff*XLEN +: XLEN];
        end
      end
      for (int w = 0; w < SET_ASSOC; w++) begin
        if (cl_wr.vld && cl_wr.we[w]) begin
          m_tag[cl_wr.idx][w]  = cl_wr.tag;
          m_vld[cl_wr.idx][w]  = cl_wr.vld_bits[w];
          m_line[cl_wr.idx][w] = cl_wr.data;
        end
        if (wr_ack && word_wr.way[w]) begin
          woff = word_wr.off[OFFSET_WIDTH-1:ALIGN_BITS];
          for (int b = 0; b < XLEN_BYTES; b++) begin
            if (word_wr.be[b]) begin
              m_line[word_wr.idx][w][woff*XLEN + b*8 +: 8] = word_wr.data[b*8 +: 8];
            end
          end
        end
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [LINE_WIDTH-1:0]   r;
    logic [LINE_WIDTH-1:0]   line;
    logic [NUM_RD_PORTS-1:0] exp_ack;
    rd_req    = '0;
    rd_prio   = '0;
    rd_addr   = '0;
    rd_tag    = '0;
    cl_wr     = '0;
    word_wr   = '0;
    error_cnt = 0;
    test_cnt  = 0;
    bad_tests = 0;
    wait (rst_ni);

    // every set starts with all ways invalid
    start_test("init_sets");
    for (int s = 0; s < NUM_SETS; s++) fill_line(IDX_WIDTH'(s), '1, '0, '0, '0);
    end_test();

    // low tag bits equal the way so a set never holds one tag twice
    start_test("fill_hit");
    for (int i = 0; i < 6; i++) begin
      rand_bits(14, r);
      r_idx[i] = {1'b0, r[4:0]};
      r_way[i] = r[7:6];
      r_tag[i] = {r[13:8], r[7:6]};
      rand_bits(LINE_WIDTH, line);
      fill_line(r_idx[i], SET_ASSOC'(1) << r_way[i], r_tag[i], '1, line);
      for (int k = 0; k < NUM_BANKS; k++) read_word(i % 2, r_idx[i], 2'(k), r_tag[i]);
    end
    end_test();

    start_test("miss");
    read_word(0, r_idx[0], 2'd0, r_tag[0] ^ 8'h80);
    read_word(1, r_idx[1], 2'd3, r_tag[1] ^ 8'h80);
    fill_line(IDX_WIDTH'(NUM_SETS - 1), '1, 8'h5a, '0, line);
    read_word(0, IDX_WIDTH'(NUM_SETS - 1), 2'd1, 8'h5a);
    end_test();

    start_test("arbitration");
    @(negedge clk_i);
    rd_addr[0] = '{idx: r_idx[0], off: 4'h4};
    rd_tag[0]  = r_tag[0];
    rd_addr[1] = '{idx: r_idx[1], off: 4'h8};
    rd_tag[1]  = r_tag[1];
    rd_req     = 2'b11;
    // port 0 held the last grant so port 1 is served first
    for (int i = 0; i < 6; i++) begin
      exp_ack = (i % 2 == 0) ? 2'b10 : 2'b01;
      @(posedge clk_i);
      assert (rd_ack == exp_ack) else report_value("round-robin ack", exp_ack, rd_ack);
    end
    @(negedge clk_i);
    rd_prio = 2'b10;
    repeat (3) begin
      @(posedge clk_i);
      assert (rd_ack == 2'b10) else report_value("high priority ack", 2'b10, rd_ack);
    end
    rand_bits(LINE_WIDTH, line);
    @(negedge clk_i);
    cl_wr = '{vld: 1'b1, we: SET_ASSOC'(1) << r_way[0], tag: r_tag[0], idx: r_idx[0],
              vld_bits: '1, data: line};
    word_wr.way = SET_ASSOC'(1) << r_way[1];
    @(posedge clk_i);
    assert (rd_ack == '0 && !wr_ack)
      else report_value("acks in a fill cycle", '0, {rd_ack, wr_ack});
    @(negedge clk_i);
    cl_wr.vld   = 1'b0;
    word_wr.way = '0;
    rd_req      = '0;
    rd_prio     = '0;
    read_word(0, r_idx[0], 2'd1, r_tag[0]);
    end_test();

    start_test("word_write");
    for (int k = 0; k < NUM_BANKS; k++) begin
      rand_bits(XLEN + XLEN_BYTES, r);
      write_word(SET_ASSOC'(1) << r_way[2], r_idx[2], 2'(k), r[XLEN-1:0], r[XLEN +: XLEN_BYTES]);
      read_word(k % 2, r_idx[2], 2'(k), r_tag[2]);
    end
    end_test();

    // same bank first so the write has to wait one cycle
    start_test("bank_collision");
    rand_bits(XLEN + XLEN_BYTES, r);
    @(negedge clk_i);
    rd_addr[0] = '{idx: r_idx[4], off: 4'h8};
    rd_tag[0]  = r_tag[4];
    rd_req[0]  = 1'b1;
    word_wr    = '{way: SET_ASSOC'(1) << r_way[3], idx: r_idx[3], off: 4'h8,
                   data: r[XLEN-1:0], be: r[XLEN +: XLEN_BYTES]};
    @(posedge clk_i);
    assert (rd_ack == 2'b01 && !wr_ack)
      else report_value("read and write acks, same bank", 3'b010, {rd_ack, wr_ack});
    @(negedge clk_i);
    rd_req[0] = 1'b0;
    @(posedge clk_i);
    assert (wr_ack) else report_value("deferred write ack", 1'b1, wr_ack);
    @(negedge clk_i);
    word_wr.way = '0;
    read_word(1, r_idx[3], 2'd2, r_tag[3]);
    rand_bits(XLEN + XLEN_BYTES, r);
    @(negedge clk_i);
    rd_addr[1] = '{idx: r_idx[4], off: 4'h4};
    rd_tag[1]  = r_tag[4];
    rd_req[1]  = 1'b1;
    word_wr    = '{way: SET_ASSOC'(1) << r_way[3], idx: r_idx[3], off: 4'hc,
                   data: r[XLEN-1:0], be: r[XLEN +: XLEN_BYTES]};
    @(posedge clk_i);
    assert (rd_ack == 2'b10 && wr_ack)
      else report_value("read and write acks, other bank", 3'b101, {rd_ack, wr_ack});
    @(negedge clk_i);
    rd_req[1]   = 1'b0;
    word_wr.way = '0;
    read_word(0, r_idx[3], 2'd3, r_tag[3]);
    end_test();

    $display("%0d tests run, %0d with errors, %0d errors in total",
             test_cnt, bad_tests, error_cnt);
    if (error_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog set to four times the expected run length
  initial begin
    #(RunCycles * 4 * ClkPeriod);
    $display("watchdog expired after %0d cycles, the tests did not finish", RunCycles * 4);
    $display("Test failed");
    $finish;
  end

endmodule
